//--- pkt_pkg.sv
// packet-side definitions for the slave agent: id widths, status codes, tracking entry layout
`default_nettype none

package pkt_pkg;

   // --------------------
   // ids and status
   // --------------------

   // source and destination ids share one width so the response can swap them
   localparam int ID_W = 3;

   // status uses the same two-bit encoding that the slave drives on m0_response
   localparam int STATUS_W = 2;

   localparam logic [STATUS_W-1:0] STATUS_OKAY   = 2'd0;
   localparam logic [STATUS_W-1:0] STATUS_SLVERR = 2'd2;

   // --------------------
   // tracking entry
   // --------------------

   // one entry per expected response: synth flag, write flag, source id, destination id
   localparam int TRACK_W = 2 + 2 * ID_W;

   // bit positions inside an entry, most significant field first
   localparam int TRK_SYNTH   = TRACK_W - 1;
   localparam int TRK_WRITE   = TRACK_W - 2;
   localparam int TRK_SRC_LO  = ID_W;
   // destination id sits in the bottom bits
   localparam int TRK_DEST_LO = 0;

endpackage

`default_nettype wire

//--- avs_pkg.sv
// slave-side definitions for the slave agent: address, data, byte enable and offset widths
`default_nettype none

package avs_pkg;

   // --------------------
   // bus widths
   // --------------------

   // byte address as carried in the command packet and driven on m0_address
   localparam int ADDR_W = 16;

   // one data word per beat, no bursts
   localparam int DATA_W = 32;

   // one enable bit per byte lane
   localparam int BE_W = DATA_W / 8;

   // --------------------
   // address masking
   // --------------------

   // low address bits that select a byte inside the word, cleared before the slave
   // sees the address (2 for a 32-bit word)
   localparam int OFFSET_W = $clog2(BE_W);

endpackage

`default_nettype wire

//--- sync_fifo.sv
// synchronous FIFO with registered full and empty flags and a head-of-queue output
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  wire              clk,
   input  wire              reset,
   input  wire              push,
   input  wire  [WIDTH-1:0] push_data,
   input  wire              pop,
   output logic [WIDTH-1:0] pop_data,
   output logic             full,
   output logic             empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;
   logic             do_push;
   logic             do_pop;

   // pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == LAST_PTR) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // an illegal push or pop leaves the state untouched
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   // --------------------
   // storage
   // --------------------

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // the head entry is visible without a pop
   assign pop_data = mem[rd_ptr];

   // --------------------
   // pointers and count
   // --------------------

   always_comb begin
      count_next = count;
      if (do_push & ~do_pop) begin
         count_next = count + 1'b1;
      end else if (do_pop & ~do_push) begin
         count_next = count - 1'b1;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         full   <= 1'b0;
         empty  <= 1'b1;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count_next;
         // flags come straight from flops so downstream logic sees no count decode
         full  <= (count_next == CNT_W'(DEPTH));
         empty <= (count_next == '0);
      end
   end

endmodule

`default_nettype wire

//--- cmd_issuer.sv
// command issuer: turns accepted command packets into slave reads and writes and tracking entries
`default_nettype none

module cmd_issuer #(
   parameter int SUPPRESS_ZERO_BYTEEN = 1
) (
   input  wire                          clk,
   input  wire                          reset,
   // command packet fields
   input  wire                          cmd_valid,
   input  wire  [avs_pkg::ADDR_W-1:0]   cmd_addr,
   input  wire  [avs_pkg::BE_W-1:0]     cmd_byteen,
   input  wire  [avs_pkg::DATA_W-1:0]   cmd_data,
   input  wire                          cmd_read,
   input  wire                          cmd_write,
   input  wire                          cmd_posted,
   input  wire  [pkt_pkg::ID_W-1:0]     cmd_src_id,
   input  wire  [pkt_pkg::ID_W-1:0]     cmd_dest_id,
   output logic                         cmd_ready,
   // slave side
   input  wire                          m0_waitrequest,
   output logic [avs_pkg::ADDR_W-1:0]   m0_address,
   output logic [avs_pkg::BE_W-1:0]     m0_byteenable,
   output logic [avs_pkg::DATA_W-1:0]   m0_writedata,
   output logic                         m0_read,
   output logic                         m0_write,
   // tracking buffer
   input  wire                          track_full,
   output logic                         track_push,
   output logic [pkt_pkg::TRACK_W-1:0]  track_entry
);

   logic issue_en;
   logic slot_ok;
   logic suppress;
   logic tracked;
   logic synth;

   // --------------------
   // issue enable
   // --------------------

   // nothing is issued while reset is applied, the flop opens the command path
   // on the first clock edge after reset is released
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         issue_en <= 1'b0;
      end else begin
         issue_en <= 1'b1;
      end
   end

   // a command may only go out when its response has somewhere to be tracked
   assign slot_ok = issue_en & ~track_full;

   // --------------------
   // suppression
   // --------------------

   // a command with no byte lane enabled would do nothing at the slave, so it is
   // kept off the bus and its response gets synthesized instead
   generate
      if (SUPPRESS_ZERO_BYTEEN != 0) begin : g_suppress
         assign suppress = ~|cmd_byteen;
      end else begin : g_no_suppress
         assign suppress = 1'b0;
      end
   endgenerate

   // suppressed commands ignore waitrequest since the slave never sees them
   assign cmd_ready = slot_ok & (~m0_waitrequest | suppress);

   // --------------------
   // slave strobes
   // --------------------

   // sub-word addresses are aligned down to the full data word
   assign m0_address    = {cmd_addr[avs_pkg::ADDR_W-1:avs_pkg::OFFSET_W],
                           {avs_pkg::OFFSET_W{1'b0}}};
   assign m0_byteenable = cmd_byteen;
   assign m0_writedata  = cmd_data;

   // strobes follow cmd_valid directly and stay up while waitrequest holds them
   assign m0_read  = cmd_valid & cmd_read & ~suppress & slot_ok;
   assign m0_write = cmd_valid & cmd_write & ~suppress & slot_ok;

   // --------------------
   // tracking entry
   // --------------------

   // every read gets a response, writes only when they are non-posted
   assign tracked    = cmd_read | (cmd_write & ~cmd_posted);
   assign track_push = cmd_valid & cmd_ready & tracked;

   // suppressed reads and all non-posted writes are answered locally
   assign synth = (cmd_read & suppress) | (cmd_write & ~cmd_posted);

   // ids go in as received, the assembler swaps them on the way out
   always_comb begin
      track_entry                                            = '0;
      track_entry[pkt_pkg::TRK_SYNTH]                        = synth;
      track_entry[pkt_pkg::TRK_WRITE]                        = cmd_write;
      track_entry[pkt_pkg::TRK_SRC_LO +: pkt_pkg::ID_W]      = cmd_src_id;
      track_entry[pkt_pkg::TRK_DEST_LO +: pkt_pkg::ID_W]     = cmd_dest_id;
   end

endmodule

`default_nettype wire

//--- rsp_assembler.sv
// response assembler: pairs tracking entries with slave read data and drives the response packet
`default_nettype none

module rsp_assembler #(
   parameter int SUPPRESS_ZERO_BYTEEN = 1
) (
   // tracking buffer head
   input  wire                                            track_empty,
   input  wire  [pkt_pkg::TRACK_W-1:0]                    track_head,
   output logic                                           track_pop,
   // read-data buffer head, status above data
   input  wire                                            rdata_empty,
   input  wire  [pkt_pkg::STATUS_W+avs_pkg::DATA_W-1:0]   rdata_head,
   output logic                                           rdata_pop,
   // response packet
   input  wire                                            rsp_ready,
   output logic                                           rsp_valid,
   output logic [avs_pkg::DATA_W-1:0]                     rsp_data,
   output logic [pkt_pkg::STATUS_W-1:0]                   rsp_status,
   output logic                                           rsp_write,
   output logic [pkt_pkg::ID_W-1:0]                       rsp_src_id,
   output logic [pkt_pkg::ID_W-1:0]                       rsp_dest_id
);

   logic                          head_write;
   logic                          synth;
   logic [pkt_pkg::STATUS_W-1:0]  slave_status;
   logic [avs_pkg::DATA_W-1:0]    slave_data;

   // --------------------
   // head decode
   // --------------------

   assign head_write = track_head[pkt_pkg::TRK_WRITE];

   // without suppression only non-posted writes are synthesized, and posted writes
   // never reach the tracking buffer, so the write flag alone decides
   generate
      if (SUPPRESS_ZERO_BYTEEN != 0) begin : g_synth_flag
         assign synth = track_head[pkt_pkg::TRK_SYNTH];
      end else begin : g_synth_write
         assign synth = head_write;
      end
   endgenerate

   assign slave_data   = rdata_head[avs_pkg::DATA_W-1:0];
   assign slave_status = rdata_head[avs_pkg::DATA_W +: pkt_pkg::STATUS_W];

   // --------------------
   // handshake
   // --------------------

   // a synthesized response needs only its tracking entry, a slave read also needs
   // its data, which arrives in the same order the reads were issued
   assign rsp_valid = ~track_empty & (synth | ~rdata_empty);

   // both heads stay put until the response is taken, so the packet holds
   // under back-pressure
   assign track_pop = rsp_valid & rsp_ready;
   assign rdata_pop = track_pop & ~synth;

   // --------------------
   // packet fields
   // --------------------

   // local responses carry zero data and OKAY, slave reads pass data and status through
   assign rsp_data   = synth ? '0 : slave_data;
   assign rsp_status = synth ? pkt_pkg::STATUS_OKAY : slave_status;
   assign rsp_write  = head_write;

   // the response travels back, so source and destination trade places
   assign rsp_src_id  = track_head[pkt_pkg::TRK_DEST_LO +: pkt_pkg::ID_W];
   assign rsp_dest_id = track_head[pkt_pkg::TRK_SRC_LO +: pkt_pkg::ID_W];

endmodule

`default_nettype wire

//--- slave_agent.sv
// memory-mapped slave agent top level: issuer, tracking and read-data buffers, response assembler
`default_nettype none

module slave_agent #(
   parameter int TRACK_DEPTH          = 4,
   parameter int SUPPRESS_ZERO_BYTEEN = 1
) (
   input  wire                          clk,
   input  wire                          reset,
   // command packet
   input  wire                          cmd_valid,
   input  wire  [avs_pkg::ADDR_W-1:0]   cmd_addr,
   input  wire  [avs_pkg::BE_W-1:0]     cmd_byteen,
   input  wire  [avs_pkg::DATA_W-1:0]   cmd_data,
   input  wire                          cmd_read,
   input  wire                          cmd_write,
   input  wire                          cmd_posted,
   input  wire  [pkt_pkg::ID_W-1:0]     cmd_src_id,
   input  wire  [pkt_pkg::ID_W-1:0]     cmd_dest_id,
   output logic                         cmd_ready,
   // memory-mapped slave
   output logic [avs_pkg::ADDR_W-1:0]   m0_address,
   output logic [avs_pkg::BE_W-1:0]     m0_byteenable,
   output logic [avs_pkg::DATA_W-1:0]   m0_writedata,
   output logic                         m0_read,
   output logic                         m0_write,
   input  wire  [avs_pkg::DATA_W-1:0]   m0_readdata,
   input  wire  [pkt_pkg::STATUS_W-1:0] m0_response,
   input  wire                          m0_readdatavalid,
   input  wire                          m0_waitrequest,
   // response packet
   input  wire                          rsp_ready,
   output logic                         rsp_valid,
   output logic [avs_pkg::DATA_W-1:0]   rsp_data,
   output logic [pkt_pkg::STATUS_W-1:0] rsp_status,
   output logic                         rsp_write,
   output logic [pkt_pkg::ID_W-1:0]     rsp_src_id,
   output logic [pkt_pkg::ID_W-1:0]     rsp_dest_id
);

   // read-data buffer word: slave status above slave data
   localparam int RDATA_W = pkt_pkg::STATUS_W + avs_pkg::DATA_W;

   // --------------------
   // internal wires
   // --------------------

   logic                         track_push;
   logic                         track_pop;
   logic                         track_full;
   logic                         track_empty;
   logic [pkt_pkg::TRACK_W-1:0]  track_entry;
   logic [pkt_pkg::TRACK_W-1:0]  track_head;

   // rdata_full has no consumer in the datapath, every stored read already holds
   // a tracking slot so this buffer cannot fill ahead of the tracking buffer
   logic                         rdata_pop;
   logic                         rdata_full;
   logic                         rdata_empty;
   logic [RDATA_W-1:0]           rdata_head;

   // --------------------
   // command path
   // --------------------

   cmd_issuer #(
      .SUPPRESS_ZERO_BYTEEN (SUPPRESS_ZERO_BYTEEN)
   ) u_issuer (
      .clk            (clk),
      .reset          (reset),
      .cmd_valid      (cmd_valid),
      .cmd_addr       (cmd_addr),
      .cmd_byteen     (cmd_byteen),
      .cmd_data       (cmd_data),
      .cmd_read       (cmd_read),
      .cmd_write      (cmd_write),
      .cmd_posted     (cmd_posted),
      .cmd_src_id     (cmd_src_id),
      .cmd_dest_id    (cmd_dest_id),
      .cmd_ready      (cmd_ready),
      .m0_waitrequest (m0_waitrequest),
      .m0_address     (m0_address),
      .m0_byteenable  (m0_byteenable),
      .m0_writedata   (m0_writedata),
      .m0_read        (m0_read),
      .m0_write       (m0_write),
      .track_full     (track_full),
      .track_push     (track_push),
      .track_entry    (track_entry)
   );

   // outstanding responses in command order
   sync_fifo #(
      .WIDTH (pkt_pkg::TRACK_W),
      .DEPTH (TRACK_DEPTH)
   ) u_track_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (track_push),
      .push_data (track_entry),
      .pop       (track_pop),
      .pop_data  (track_head),
      .full      (track_full),
      .empty     (track_empty)
   );

   // --------------------
   // return path
   // --------------------

   // slave read data is captured as it returns, in issue order
   sync_fifo #(
      .WIDTH (RDATA_W),
      .DEPTH (TRACK_DEPTH)
   ) u_rdata_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (m0_readdatavalid),
      .push_data ({m0_response, m0_readdata}),
      .pop       (rdata_pop),
      .pop_data  (rdata_head),
      .full      (rdata_full),
      .empty     (rdata_empty)
   );

   rsp_assembler #(
      .SUPPRESS_ZERO_BYTEEN (SUPPRESS_ZERO_BYTEEN)
   ) u_assembler (
      .track_empty (track_empty),
      .track_head  (track_head),
      .track_pop   (track_pop),
      .rdata_empty (rdata_empty),
      .rdata_head  (rdata_head),
      .rdata_pop   (rdata_pop),
      .rsp_ready   (rsp_ready),
      .rsp_valid   (rsp_valid),
      .rsp_data    (rsp_data),
      .rsp_status  (rsp_status),
      .rsp_write   (rsp_write),
      .rsp_src_id  (rsp_src_id),
      .rsp_dest_id (rsp_dest_id)
   );

endmodule

`default_nettype wire

//--- slave_agent_assertions.sv
// protocol assertions for the slave agent, bound into every slave_agent instance
`default_nettype none

module slave_agent_assertions (
   input wire                          clk,
   input wire                          reset,
   input wire                          m0_read,
   input wire                          m0_write,
   input wire                          m0_readdatavalid,
   input wire                          rsp_valid,
   input wire                          rsp_ready,
   input wire [avs_pkg::DATA_W-1:0]    rsp_data,
   input wire [pkt_pkg::STATUS_W-1:0]  rsp_status,
   input wire                          rsp_write,
   input wire [pkt_pkg::ID_W-1:0]      rsp_src_id,
   input wire [pkt_pkg::ID_W-1:0]      rsp_dest_id,
   input wire                          track_push,
   input wire                          track_full,
   input wire                          rdata_full
);

   // a command is either a read or a write, so the bus never carries both
   a_strobe_excl : assert property (@(posedge clk) disable iff (reset)
      !(m0_read && m0_write))
      else $error("m0_read and m0_write were high in the same cycle");

   // a stalled response keeps its valid and every field until it is taken
   a_rsp_hold : assert property (@(posedge clk) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_status)
         && $stable(rsp_write) && $stable(rsp_src_id) && $stable(rsp_dest_id))
      else $error("response changed or dropped while rsp_ready was low");

   // --------------------
   // buffer overflow
   // --------------------

   // the issuer must stall commands once every tracking slot is taken
   a_track_no_overflow : assert property (@(posedge clk) disable iff (reset)
      !(track_push && track_full))
      else $error("tracking buffer pushed while full");

   // read data always has a tracking slot waiting, so this buffer fills last
   a_rdata_no_overflow : assert property (@(posedge clk) disable iff (reset)
      !(m0_readdatavalid && rdata_full))
      else $error("read-data buffer pushed while full");

endmodule

bind slave_agent slave_agent_assertions u_assertions (
   .clk              (clk),
   .reset            (reset),
   .m0_read          (m0_read),
   .m0_write         (m0_write),
   .m0_readdatavalid (m0_readdatavalid),
   .rsp_valid        (rsp_valid),
   .rsp_ready        (rsp_ready),
   .rsp_data         (rsp_data),
   .rsp_status       (rsp_status),
   .rsp_write        (rsp_write),
   .rsp_src_id       (rsp_src_id),
   .rsp_dest_id      (rsp_dest_id),
   .track_push       (track_push),
   .track_full       (track_full),
   .rdata_full       (rdata_full)
);

`default_nettype wire

//--- slave_agent_tb.sv
// testbench for the slave agent: random commands, a slave memory model and a reference check
`default_nettype none

module slave_agent_tb;

   localparam int TRACK_DEPTH = 4;
   localparam int NUM_RANDOM  = 200;
   // random phase, the buffer fill phase and the one command that has to wait
   localparam int NUM_CMDS    = NUM_RANDOM + TRACK_DEPTH + 1;
   localparam int TIMEOUT     = 20 * NUM_CMDS + 200;
   localparam int MEM_WORDS   = 64;
   localparam int IDX_W       = 6;

   // expected response word: write flag, status, response source, response destination, data
   localparam int EXP_W       = 1 + pkt_pkg::STATUS_W + 2 * pkt_pkg::ID_W + avs_pkg::DATA_W;
   localparam int RSP_DEST_LO = avs_pkg::DATA_W;
   localparam int RSP_SRC_LO  = avs_pkg::DATA_W + pkt_pkg::ID_W;
   localparam int STATUS_LO   = avs_pkg::DATA_W + 2 * pkt_pkg::ID_W;

   logic                          clk = 1'b0;
   logic                          reset = 1'b1;
   logic                          cmd_valid = 1'b0;
   logic [avs_pkg::ADDR_W-1:0]    cmd_addr = '0;
   logic [avs_pkg::BE_W-1:0]      cmd_byteen = '0;
   logic [avs_pkg::DATA_W-1:0]    cmd_data = '0;
   logic                          cmd_read = 1'b0;
   logic                          cmd_write = 1'b0;
   logic                          cmd_posted = 1'b0;
   logic [pkt_pkg::ID_W-1:0]      cmd_src_id = '0;
   logic [pkt_pkg::ID_W-1:0]      cmd_dest_id = '0;
   logic                          cmd_ready;
   logic [avs_pkg::ADDR_W-1:0]    m0_address;
   logic [avs_pkg::BE_W-1:0]      m0_byteenable;
   logic [avs_pkg::DATA_W-1:0]    m0_writedata;
   logic                          m0_read;
   logic                          m0_write;
   logic [avs_pkg::DATA_W-1:0]    m0_readdata = '0;
   logic [pkt_pkg::STATUS_W-1:0]  m0_response = '0;
   logic                          m0_readdatavalid = 1'b0;
   logic                          m0_waitrequest = 1'b0;
   logic                          rsp_ready = 1'b0;
   logic                          rsp_valid;
   logic [avs_pkg::DATA_W-1:0]    rsp_data;
   logic [pkt_pkg::STATUS_W-1:0]  rsp_status;
   logic                          rsp_write;
   logic [pkt_pkg::ID_W-1:0]      rsp_src_id;
   logic [pkt_pkg::ID_W-1:0]      rsp_dest_id;

   // testbench state
   logic                          ready_low = 1'b0;
   int                            cycle_count = 0;
   logic [avs_pkg::DATA_W-1:0]    slave_mem [MEM_WORDS];
   logic [avs_pkg::DATA_W-1:0]    mirror [MEM_WORDS];
   logic                          rd_pend = 1'b0;
   logic [avs_pkg::DATA_W-1:0]    rd_word = '0;
   logic [pkt_pkg::STATUS_W-1:0]  rd_status = '0;
   logic [EXP_W-1:0]              exp_q [$];
   logic [EXP_W-1:0]              exp_head;

   always #4 clk = ~clk;

   slave_agent #(
      .TRACK_DEPTH          (TRACK_DEPTH),
      .SUPPRESS_ZERO_BYTEEN (1)
   ) i_slave_agent (
      .clk              (clk),
      .reset            (reset),
      .cmd_valid        (cmd_valid),
      .cmd_addr         (cmd_addr),
      .cmd_byteen       (cmd_byteen),
      .cmd_data         (cmd_data),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_posted       (cmd_posted),
      .cmd_src_id       (cmd_src_id),
      .cmd_dest_id      (cmd_dest_id),
      .cmd_ready        (cmd_ready),
      .m0_address       (m0_address),
      .m0_byteenable    (m0_byteenable),
      .m0_writedata     (m0_writedata),
      .m0_read          (m0_read),
      .m0_write         (m0_write),
      .m0_readdata      (m0_readdata),
      .m0_response      (m0_response),
      .m0_readdatavalid (m0_readdatavalid),
      .m0_waitrequest   (m0_waitrequest),
      .rsp_ready        (rsp_ready),
      .rsp_valid        (rsp_valid),
      .rsp_data         (rsp_data),
      .rsp_status       (rsp_status),
      .rsp_write        (rsp_write),
      .rsp_src_id       (rsp_src_id),
      .rsp_dest_id      (rsp_dest_id)
   );

   // --------------------
   // helpers
   // --------------------

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_data(input string name, input logic [avs_pkg::DATA_W-1:0] got,
                             input logic [avs_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // status, ids and write flag of one response
   task automatic check_tag(input logic [pkt_pkg::STATUS_W-1:0] got_status,
                            input logic [pkt_pkg::STATUS_W-1:0] exp_status,
                            input logic [pkt_pkg::ID_W-1:0] got_src,
                            input logic [pkt_pkg::ID_W-1:0] exp_src,
                            input logic [pkt_pkg::ID_W-1:0] got_dest,
                            input logic [pkt_pkg::ID_W-1:0] exp_dest,
                            input logic got_write, input logic exp_write);
      if (got_status !== exp_status) begin
         fail_now($sformatf("[FAIL] rsp_status got 0x%h expected 0x%h", got_status, exp_status));
      end else if (got_src !== exp_src) begin
         fail_now($sformatf("[FAIL] rsp_src_id got 0x%h expected 0x%h", got_src, exp_src));
      end else if (got_dest !== exp_dest) begin
         fail_now($sformatf("[FAIL] rsp_dest_id got 0x%h expected 0x%h", got_dest, exp_dest));
      end else if (got_write !== exp_write) begin
         fail_now($sformatf("[FAIL] rsp_write got 0x%h expected 0x%h", got_write, exp_write));
      end
   endtask

   // start value of a memory word, built from every bit of its index
   function automatic logic [avs_pkg::DATA_W-1:0] fill_word(input int idx);
      return {8'(idx), 8'(idx * 7 + 3), 8'(~idx), 8'(idx ^ 8'h5a)};
   endfunction

   // the slave sees the byte address rounded down to the start of its data word
   function automatic logic [avs_pkg::ADDR_W-1:0] word_address(
         input logic [avs_pkg::ADDR_W-1:0] addr);
      return (addr >> avs_pkg::OFFSET_W) << avs_pkg::OFFSET_W;
   endfunction

   // reference model: zero data and OKAY unless a read with enabled lanes reaches the slave,
   // which returns the mirror word, and SLVERR for the top half of the address space
   function automatic logic [EXP_W-1:0] expect_response(
         input logic rd, input logic [avs_pkg::ADDR_W-1:0] addr,
         input logic [avs_pkg::BE_W-1:0] be,
         input logic [pkt_pkg::ID_W-1:0] src, input logic [pkt_pkg::ID_W-1:0] dest);
      logic [avs_pkg::DATA_W-1:0]   data;
      logic [pkt_pkg::STATUS_W-1:0] status;
      data   = '0;
      status = pkt_pkg::STATUS_OKAY;
      if (rd && be != '0) begin
         data = mirror[addr[avs_pkg::OFFSET_W +: IDX_W]];
         if (addr[avs_pkg::ADDR_W-1]) begin
            status = pkt_pkg::STATUS_SLVERR;
         end
      end
      // the response goes back to where the command came from
      return {!rd, status, dest, src, data};
   endfunction

   // holds one command until the DUT takes it
   task automatic send_cmd(input logic rd, input logic posted,
                           input logic [avs_pkg::ADDR_W-1:0] addr,
                           input logic [avs_pkg::BE_W-1:0] be,
                           input logic [avs_pkg::DATA_W-1:0] data,
                           input logic [pkt_pkg::ID_W-1:0] src,
                           input logic [pkt_pkg::ID_W-1:0] dest);
      cmd_valid   <= 1'b1;
      cmd_read    <= rd;
      cmd_write   <= !rd;
      cmd_posted  <= posted;
      cmd_addr    <= addr;
      cmd_byteen  <= be;
      cmd_data    <= data;
      cmd_src_id  <= src;
      cmd_dest_id <= dest;
      do begin
         @(posedge clk);
      end while (!cmd_ready);
      cmd_valid <= 1'b0;
   endtask

   // one random read or write, about one in five with no byte lane enabled
   task automatic random_cmd();
      logic [31:0]               r;
      logic [avs_pkg::BE_W-1:0]  be;
      r  = $urandom;
      be = ($urandom % 5 == 0) ? '0 : r[31 -: avs_pkg::BE_W];
      send_cmd(r[27], r[26], r[avs_pkg::ADDR_W-1:0], be, $urandom,
               r[16 +: pkt_pkg::ID_W], r[20 +: pkt_pkg::ID_W]);
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
   endtask

   // --------------------
   // slave model
   // --------------------

   // reads come back two cycles after they are issued, random waitrequest
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            slave_mem[i] = fill_word(i);
         end
         m0_waitrequest   <= 1'b0;
         m0_readdatavalid <= 1'b0;
         rd_pend          <= 1'b0;
      end else begin
         if (m0_read || m0_write) begin
            if (!cmd_valid || cmd_byteen == '0) begin
               fail_now("slave strobe raised without a valid command with enabled bytes");
            end
            if (m0_address !== word_address(cmd_addr)) begin
               fail_now($sformatf("[FAIL] m0_address got 0x%h expected 0x%h", m0_address,
                                  word_address(cmd_addr)));
            end
         end
         rd_pend <= m0_read && !m0_waitrequest;
         if (m0_read && !m0_waitrequest) begin
            rd_word   <= slave_mem[m0_address[avs_pkg::OFFSET_W +: IDX_W]];
            rd_status <= m0_address[avs_pkg::ADDR_W-1] ? pkt_pkg::STATUS_SLVERR
                                                       : pkt_pkg::STATUS_OKAY;
         end
         if (m0_write && !m0_waitrequest) begin
            for (int b = 0; b < avs_pkg::BE_W; b++) begin
               if (m0_byteenable[b]) begin
                  slave_mem[m0_address[avs_pkg::OFFSET_W +: IDX_W]][8*b +: 8] =
                     m0_writedata[8*b +: 8];
               end
            end
         end
         m0_readdatavalid <= rd_pend;
         m0_readdata      <= rd_word;
         m0_response      <= rd_status;
         m0_waitrequest   <= ($urandom % 4) == 0;
      end
   end

   // response back-pressure, random unless a test holds it low
   always @(posedge clk) begin
      rsp_ready <= !reset && !ready_low && ($urandom % 3 != 0);
   end

   // --------------------
   // scoreboard
   // --------------------

   // expected response is worked out at acceptance, before the mirror sees later writes
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mirror[i] = fill_word(i);
         end
      end else if (cmd_valid && cmd_ready) begin
         if (cmd_read || !cmd_posted) begin
            exp_q.push_back(expect_response(cmd_read, cmd_addr, cmd_byteen,
                                            cmd_src_id, cmd_dest_id));
         end
         if (cmd_write) begin
            for (int b = 0; b < avs_pkg::BE_W; b++) begin
               if (cmd_byteen[b]) begin
                  mirror[cmd_addr[avs_pkg::OFFSET_W +: IDX_W]][8*b +: 8] = cmd_data[8*b +: 8];
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      if (!reset && rsp_valid && rsp_ready) begin
         if (exp_q.size() == 0) begin
            fail_now("a response was returned with no command outstanding");
         end else begin
            exp_head = exp_q.pop_front();
            check_data("rsp_data", rsp_data, exp_head[avs_pkg::DATA_W-1:0]);
            check_tag(rsp_status, exp_head[STATUS_LO +: pkt_pkg::STATUS_W],
                      rsp_src_id, exp_head[RSP_SRC_LO +: pkt_pkg::ID_W],
                      rsp_dest_id, exp_head[RSP_DEST_LO +: pkt_pkg::ID_W],
                      rsp_write, exp_head[EXP_W-1]);
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT) begin
         fail_now($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT));
      end
   end

   // --------------------
   // stimulus
   // --------------------

   initial begin
      logic [31:0] r;
      void'($urandom(32'ha1501446));
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      // mixed traffic with random back-pressure on both sides
      for (int n = 0; n < NUM_RANDOM; n++) begin
         random_cmd();
         if ($urandom % 4 == 0) begin
            @(posedge clk);
         end
      end
      wait_drained();
      // fill every tracking slot while no response can leave
      ready_low <= 1'b1;
      repeat (2) @(posedge clk);
      for (int k = 0; k < TRACK_DEPTH; k++) begin
         r = $urandom;
         send_cmd(k % 2 == 0, 1'b0, r[avs_pkg::ADDR_W-1:0], {avs_pkg::BE_W{1'b1}}, $urandom,
                  r[16 +: pkt_pkg::ID_W], r[20 +: pkt_pkg::ID_W]);
      end
      @(posedge clk);
      if (cmd_ready) begin
         fail_now("cmd_ready stayed high with every tracking slot in use");
      end
      // the oldest command is a read whose data has had time to come back
      if (!rsp_valid) begin
         fail_now("no response was offered while every tracking slot was in use");
      end
      // one more command waits until responses drain again
      r = $urandom;
      fork
         send_cmd(1'b1, 1'b0, r[avs_pkg::ADDR_W-1:0], {avs_pkg::BE_W{1'b1}}, '0,
                  r[16 +: pkt_pkg::ID_W], r[20 +: pkt_pkg::ID_W]);
         begin
            repeat (12) @(posedge clk);
            ready_low <= 1'b0;
         end
      join
      wait_drained();
      repeat (20) @(posedge clk);
      // with every expected response taken the DUT has nothing left to offer
      if (exp_q.size() != 0 || rsp_valid) begin
         fail_now("responses were still outstanding or offered at the end of the run");
      end else begin
         $display("PASS: all tests");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- slave_agent.f
pkt_pkg.sv
avs_pkg.sv
sync_fifo.sv
cmd_issuer.sv
rsp_assembler.sv
slave_agent.sv
slave_agent_assertions.sv
slave_agent_tb.sv

//--- Makefile
# Verilator build and run of the slave agent testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module slave_agent_tb -f slave_agent.f
	./obj_dir/Vslave_agent_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" sim.log; then \
	   echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
